// File: rtl/axiAhbPkg.sv
package axiAhbPkg;

    //////////////////////////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////////////////////////

    // AXI and AHB byte address
    localparam int ADDR_W = 32;
    // One write beat
    localparam int DATA_W = 64;
    // One strobe bit per data byte
    localparam int STRB_W = DATA_W / 8;
    // AWLEN field, up to 16 beats
    localparam int LEN_W = 4;
    localparam int ID_W = 4;

    // Write buffer holds one full burst
    localparam int BUF_ADDR_W = 4;
    // Enough for 16 beats of 8 bytes
    localparam int BYTE_CNT_W = 8;
    // Byte lane index inside a beat
    localparam int OFFSET_W = 3;

    //////////////////////////////////////////////////////////////////////
    // AXI field encodings
    //////////////////////////////////////////////////////////////////////

    // AWSIZE for 8-byte beats, the only size handled
    localparam logic [2:0] SIZE_64 = 3'd3;

    // AWBURST codes
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10,
        BURST_RSVD  = 2'b11
    } burstT;

    // BRESP codes, EXOKAY and DECERR are never returned
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } respT;

endpackage

// File: rtl/wrBeatIf.sv
`timescale 1ns/10ps

// Per-beat control between the write FSM and the datapath blocks
interface wrBeatIf;

    // From the FSM
    logic addrAccept;
    logic beatAccept;
    logic beatStore;
    logic burstDone;

    // From the burst tracker
    logic lastBeatNext;
    logic burstBad;
    logic firstBeat;

    modport ctrl (
        output addrAccept, beatAccept, beatStore, burstDone,
        input  lastBeatNext, burstBad, firstBeat
    );

    modport dp (
        input  addrAccept, beatAccept, beatStore, burstDone,
        output lastBeatNext, burstBad, firstBeat
    );

endinterface

// File: rtl/axiWrCtrl.sv
`timescale 1ns/10ps

module axiWrCtrl (
    input  logic                        ACLK,
    input  logic                        ARESETN,
    input  logic                        AWVALID,
    input  logic                        WVALID,
    input  logic                        WLAST,
    input  logic                        BREADY,
    input  logic                        ahbWrDone,
    input  logic                        ahbError,
    input  logic [axiAhbPkg::ID_W-1:0]  capturedId,
    output logic                        AWREADY,
    output logic                        WREADY,
    output logic                        BVALID,
    output axiAhbPkg::respT             BRESP,
    output logic [axiAhbPkg::ID_W-1:0]  BID,
    output logic                        wrTranPend,
    wrBeatIf.ctrl                       beat
);

    import axiAhbPkg::*;

    typedef enum logic [2:0] {
        stIdle,
        stData,
        stLast,
        stWaitLast,
        stAhbWait,
        stResp
    } stateT;

    stateT state;
    stateT nextState;

    // Sticky error for the burst in flight
    logic errFlag;
    // Previous done level for toggle detection
    logic doneReg;
    logic doneEdge;
    // Clean last beat, handed to the AHB side
    logic handOver;

    //////////////////////////////////////////////////////////////////////
    // Handshake decode, all from state
    //////////////////////////////////////////////////////////////////////

    assign AWREADY = (state == stIdle);
    assign WREADY  = (state == stData) || (state == stLast) || (state == stWaitLast);
    assign BVALID  = (state == stResp);
    assign BRESP   = errFlag ? RESP_SLVERR : RESP_OKAY;
    assign BID     = capturedId;

    assign beat.addrAccept = AWREADY && AWVALID;
    assign beat.beatAccept = WREADY && WVALID;

    // Only beats of an error-free burst reach the buffer
    // Early WLAST and missing WLAST beats are dropped
    assign beat.beatStore = beat.beatAccept && !errFlag &&
                            (((state == stData) && !WLAST) ||
                             ((state == stLast) && WLAST));

    // Burst is over once a beat leaves the W phase
    assign beat.burstDone = beat.beatAccept && WLAST &&
                            ((state == stLast) || (state == stWaitLast));

    assign handOver = (state == stLast) && beat.beatAccept && WLAST && !errFlag;

    // Any change of the done level ends the AHB transfer
    assign doneEdge = doneReg ^ ahbWrDone;

    //////////////////////////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ACLK or negedge ARESETN)
    begin
        if (!ARESETN)
            state <= stIdle;
        else
            state <= nextState;
    end

    always_comb
    begin
        nextState = state;
        case (state)
            stIdle:
            begin
                // Single-beat bursts skip straight to the last beat
                if (beat.addrAccept)
                    nextState = beat.lastBeatNext ? stLast : stData;
            end
            stData:
            begin
                if (beat.beatAccept && beat.lastBeatNext)
                    nextState = stLast;
            end
            stLast:
            begin
                if (beat.beatAccept)
                begin
                    if (!WLAST)
                        nextState = stWaitLast;
                    else if (errFlag)
                        nextState = stResp;
                    else
                        nextState = stAhbWait;
                end
            end
            stWaitLast:
            begin
                // Drain beats until the master ends its burst
                if (beat.beatAccept && WLAST)
                    nextState = stResp;
            end
            stAhbWait:
            begin
                if (doneEdge)
                    nextState = stResp;
            end
            stResp:
            begin
                if (BREADY)
                    nextState = stIdle;
            end
            default:
                nextState = stIdle;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Error flag, pending toggle and done edge
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ACLK or negedge ARESETN)
    begin
        if (!ARESETN)
        begin
            errFlag    <= 1'b0;
            wrTranPend <= 1'b0;
            doneReg    <= 1'b0;
        end
        else
        begin
            doneReg <= ahbWrDone;
            if (handOver)
                wrTranPend <= !wrTranPend;

            if (beat.addrAccept)
                // Illegal burst type or size, checked once
                errFlag <= beat.burstBad;
            else if ((state == stData) && beat.beatAccept && WLAST)
                // WLAST ahead of the last beat
                errFlag <= 1'b1;
            else if ((state == stLast) && beat.beatAccept && !WLAST)
                // WLAST missing on the last beat
                errFlag <= 1'b1;
            else if ((state == stAhbWait) && doneEdge)
                // ahbError is already stable when done toggles
                errFlag <= ahbError;
            else if ((state == stResp) && BREADY)
                errFlag <= 1'b0;
        end
    end

endmodule

// File: rtl/wrBurstTracker.sv
`timescale 1ns/10ps

module wrBurstTracker (
    input  logic                            ACLK,
    input  logic                            ARESETN,
    input  logic [axiAhbPkg::LEN_W-1:0]     AWLEN,
    input  logic [1:0]                      AWBURST,
    input  logic [2:0]                      AWSIZE,
    input  logic [axiAhbPkg::ID_W-1:0]      AWID,
    output logic [axiAhbPkg::ID_W-1:0]      capturedId,
    output logic [axiAhbPkg::LEN_W-1:0]     ahbLen,
    output logic [1:0]                      ahbBurst,
    output logic [axiAhbPkg::BUF_ADDR_W-1:0] wrBufAddr,
    wrBeatIf.dp                             beat
);

    import axiAhbPkg::*;

    logic [LEN_W-1:0]      beatCnt;
    logic [BUF_ADDR_W-1:0] bufPtr;

    //////////////////////////////////////////////////////////////////////
    // Address phase capture
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ACLK)
    begin
        if (beat.addrAccept)
        begin
            capturedId <= AWID;
            ahbLen     <= AWLEN;
            ahbBurst   <= AWBURST;
        end
    end

    // Only FIXED and INCR with 8-byte beats are accepted
    assign beat.burstBad = (AWBURST == BURST_RSVD) || (AWBURST == BURST_WRAP) ||
                           (AWSIZE != SIZE_64);

    //////////////////////////////////////////////////////////////////////
    // Beat counter and buffer pointer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ACLK or negedge ARESETN)
    begin
        if (!ARESETN)
        begin
            beatCnt <= '0;
            bufPtr  <= '0;
        end
        else if (beat.burstDone)
        begin
            beatCnt <= '0;
            bufPtr  <= '0;
        end
        else
        begin
            // Counts every handshake, stored or dropped
            if (beat.beatAccept)
                beatCnt <= beatCnt + 1'b1;
            if (beat.beatStore)
                bufPtr <= bufPtr + 1'b1;
        end
    end

    // At the AW handshake the length is still on the bus
    assign beat.lastBeatNext = beat.addrAccept ? (AWLEN == '0) :
                                                 ((beatCnt + 1'b1) == ahbLen);
    assign beat.firstBeat    = (beatCnt == '0);

    // Pointer is the address of the beat being stored now
    assign wrBufAddr = bufPtr;

endmodule

// File: rtl/strobeAccumulator.sv
`timescale 1ns/10ps

module strobeAccumulator (
    input  logic                            ACLK,
    input  logic                            ARESETN,
    input  logic [axiAhbPkg::ADDR_W-1:0]    AWADDR,
    input  logic [axiAhbPkg::STRB_W-1:0]    WSTRB,
    input  logic [axiAhbPkg::DATA_W-1:0]    WDATA,
    output logic [axiAhbPkg::ADDR_W-1:0]    ahbAddr,
    output logic [axiAhbPkg::BYTE_CNT_W-1:0] validByteCnt,
    output logic                            wrBufWrEn,
    output logic [axiAhbPkg::DATA_W-1:0]    wrBufData,
    wrBeatIf.dp                             beat
);

    import axiAhbPkg::*;

    // Number of set strobes, 0 to 8
    logic [OFFSET_W:0]   popCnt;
    // Index of the lowest set strobe
    logic [OFFSET_W-1:0] lowLane;

    //////////////////////////////////////////////////////////////////////
    // Strobe decode
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        popCnt  = '0;
        lowLane = '0;
        // Downward scan so the lowest set lane wins
        for (int i = STRB_W - 1; i >= 0; i--)
        begin
            if (WSTRB[i])
            begin
                popCnt  = popCnt + 1'b1;
                lowLane = OFFSET_W'(i);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Start address and byte count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ACLK)
    begin
        // Align down to a beat, then offset by the first beat's strobes
        if (beat.addrAccept)
            ahbAddr <= {AWADDR[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        else if (beat.beatStore && beat.firstBeat)
            ahbAddr <= ahbAddr + ADDR_W'(lowLane);
    end

    always_ff @(posedge ACLK or negedge ARESETN)
    begin
        if (!ARESETN)
            validByteCnt <= '0;
        else if (beat.beatStore)
        begin
            // First beat restarts the count
            if (beat.firstBeat)
                validByteCnt <= BYTE_CNT_W'(popCnt);
            else
                validByteCnt <= validByteCnt + BYTE_CNT_W'(popCnt);
        end
    end

    // Buffer write happens in the handshake cycle itself
    assign wrBufWrEn = beat.beatStore;
    assign wrBufData = WDATA;

endmodule

// File: rtl/axiToAhbWrBridge.sv
`timescale 1ns/10ps

module axiToAhbWrBridge (
    input  logic                             ACLK,
    input  logic                             ARESETN,
    // AXI write address channel
    input  logic                             AWVALID,
    output logic                             AWREADY,
    input  logic [axiAhbPkg::ADDR_W-1:0]     AWADDR,
    input  logic [axiAhbPkg::LEN_W-1:0]      AWLEN,
    input  logic [2:0]                       AWSIZE,
    input  logic [1:0]                       AWBURST,
    input  logic [axiAhbPkg::ID_W-1:0]       AWID,
    // AXI write data channel
    input  logic                             WVALID,
    output logic                             WREADY,
    input  logic [axiAhbPkg::DATA_W-1:0]     WDATA,
    input  logic [axiAhbPkg::STRB_W-1:0]     WSTRB,
    input  logic                             WLAST,
    // AXI write response channel
    output logic                             BVALID,
    input  logic                             BREADY,
    output axiAhbPkg::respT                  BRESP,
    output logic [axiAhbPkg::ID_W-1:0]       BID,
    // Write buffer
    output logic                             wrBufWrEn,
    output logic [axiAhbPkg::BUF_ADDR_W-1:0] wrBufAddr,
    output logic [axiAhbPkg::DATA_W-1:0]     wrBufData,
    // AHB master side
    output logic [axiAhbPkg::ADDR_W-1:0]     ahbAddr,
    output logic [axiAhbPkg::LEN_W-1:0]      ahbLen,
    output logic [1:0]                       ahbBurst,
    output logic                             wrTranPend,
    output logic [axiAhbPkg::BYTE_CNT_W-1:0] validByteCnt,
    input  logic                             ahbWrDone,
    input  logic                             ahbError
);

    import axiAhbPkg::*;

    // ID of the burst in flight, returned on B
    logic [ID_W-1:0] capturedId;

    wrBeatIf beat ();

    //////////////////////////////////////////////////////////////////////
    // Write FSM and response
    //////////////////////////////////////////////////////////////////////

    axiWrCtrl u_axiWrCtrl (
        .ACLK       (ACLK),
        .ARESETN    (ARESETN),
        .AWVALID    (AWVALID),
        .WVALID     (WVALID),
        .WLAST      (WLAST),
        .BREADY     (BREADY),
        .ahbWrDone  (ahbWrDone),
        .ahbError   (ahbError),
        .capturedId (capturedId),
        .AWREADY    (AWREADY),
        .WREADY     (WREADY),
        .BVALID     (BVALID),
        .BRESP      (BRESP),
        .BID        (BID),
        .wrTranPend (wrTranPend),
        .beat       (beat.ctrl)
    );

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////

    wrBurstTracker u_wrBurstTracker (
        .ACLK       (ACLK),
        .ARESETN    (ARESETN),
        .AWLEN      (AWLEN),
        .AWBURST    (AWBURST),
        .AWSIZE     (AWSIZE),
        .AWID       (AWID),
        .capturedId (capturedId),
        .ahbLen     (ahbLen),
        .ahbBurst   (ahbBurst),
        .wrBufAddr  (wrBufAddr),
        .beat       (beat.dp)
    );

    strobeAccumulator u_strobeAccumulator (
        .ACLK         (ACLK),
        .ARESETN      (ARESETN),
        .AWADDR       (AWADDR),
        .WSTRB        (WSTRB),
        .WDATA        (WDATA),
        .ahbAddr      (ahbAddr),
        .validByteCnt (validByteCnt),
        .wrBufWrEn    (wrBufWrEn),
        .wrBufData    (wrBufData),
        .beat         (beat.dp)
    );

endmodule

// File: testbench/tbClockGen.sv
`timescale 1ns/10ps

module tbClockGen (
    output logic ACLK,
    output logic ARESETN
);

    // 10 ns clock period
    localparam int PERIOD = 10;

    initial
    begin
        ACLK = 1'b0;
        forever #(PERIOD / 2) ACLK = ~ACLK;
    end

    // Reset held over two rising edges, released on a falling edge
    initial
    begin
        ARESETN = 1'b0;
        repeat (2) @(negedge ACLK);
        ARESETN = 1'b1;
    end

endmodule

// File: testbench/tbTop.sv
`timescale 1ns/10ps

module tbTop;

    import axiAhbPkg::*;

    // Test row with address phase, first strobe, error injection and AHB reply
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        burstT             burst;
        logic [2:0]        size;
        logic [STRB_W-1:0] firstStrb;
        logic [4:0]        earlyLast;
        logic              noLast;
        logic              ahbErr;
    } rowT;

    localparam logic [4:0] NO_EARLY = 5'h1f;
    localparam int NUM_ROWS = 14;
    // Per-row bound covers 17 beats plus the AHB delay
    localparam int CYCLE_LIMIT = 200 * NUM_ROWS;

    rowT rows [NUM_ROWS] = '{
        '{32'h0000_1000, 4'd3,  BURST_INCR,  SIZE_64, 8'hff, NO_EARLY, 1'b0, 1'b0},
        '{32'h0000_2005, 4'd2,  BURST_INCR,  SIZE_64, 8'he0, NO_EARLY, 1'b0, 1'b0},
        '{32'h0000_3010, 4'd0,  BURST_INCR,  SIZE_64, 8'h0c, NO_EARLY, 1'b0, 1'b0},
        '{32'h0000_4000, 4'd15, BURST_INCR,  SIZE_64, 8'hff, NO_EARLY, 1'b0, 1'b0},
        '{32'h0000_5000, 4'd1,  BURST_FIXED, SIZE_64, 8'h81, NO_EARLY, 1'b0, 1'b0},
        // Illegal address phase
        '{32'h0000_6000, 4'd3,  BURST_RSVD,  SIZE_64, 8'hff, NO_EARLY, 1'b0, 1'b0},
        '{32'h0000_7000, 4'd3,  BURST_WRAP,  SIZE_64, 8'hff, NO_EARLY, 1'b0, 1'b0},
        '{32'h0000_8000, 4'd2,  BURST_INCR,  3'd2,    8'hff, NO_EARLY, 1'b0, 1'b0},
        // WLAST protocol errors
        '{32'h0000_9000, 4'd4,  BURST_INCR,  SIZE_64, 8'hff, 5'd2,     1'b0, 1'b0},
        '{32'h0000_a000, 4'd3,  BURST_INCR,  SIZE_64, 8'hff, NO_EARLY, 1'b1, 1'b0},
        // AHB side error, then a clean burst
        '{32'h0000_b000, 4'd2,  BURST_INCR,  SIZE_64, 8'hff, NO_EARLY, 1'b0, 1'b1},
        '{32'h0000_c00b, 4'd1,  BURST_INCR,  SIZE_64, 8'hf0, NO_EARLY, 1'b0, 1'b0},
        '{32'h0000_d000, 4'd0,  BURST_INCR,  SIZE_64, 8'hff, NO_EARLY, 1'b1, 1'b0},
        '{32'h0000_e000, 4'd1,  BURST_INCR,  SIZE_64, 8'hff, 5'd0,     1'b0, 1'b0}
    };

    logic                  ACLK;
    logic                  ARESETN;
    logic                  AWVALID;
    logic                  AWREADY;
    logic [ADDR_W-1:0]     AWADDR;
    logic [LEN_W-1:0]      AWLEN;
    logic [2:0]            AWSIZE;
    logic [1:0]            AWBURST;
    logic [ID_W-1:0]       AWID;
    logic                  WVALID;
    logic                  WREADY;
    logic [DATA_W-1:0]     WDATA;
    logic [STRB_W-1:0]     WSTRB;
    logic                  WLAST;
    logic                  BVALID;
    logic                  BREADY;
    respT                  BRESP;
    logic [ID_W-1:0]       BID;
    logic                  wrBufWrEn;
    logic [BUF_ADDR_W-1:0] wrBufAddr;
    logic [DATA_W-1:0]     wrBufData;
    logic [ADDR_W-1:0]     ahbAddr;
    logic [LEN_W-1:0]      ahbLen;
    logic [1:0]            ahbBurst;
    logic                  wrTranPend;
    logic [BYTE_CNT_W-1:0] validByteCnt;
    logic                  ahbWrDone;
    logic                  ahbError;

    integer seed = 32'hdc78;
    // AHB reply for the row in flight
    logic curAhbErr;
    int   cycleCnt = 0;
    int   writeCnt = 0;
    int   pendChanges = 0;
    logic prevPend = 1'b0;

    tbClockGen u_tbClockGen (.ACLK(ACLK), .ARESETN(ARESETN));

    axiToAhbWrBridge u_axiToAhbWrBridge (.*);

    //////////////////////////////////////////////////////////////////////
    // Compare, reference model and monitors
    //////////////////////////////////////////////////////////////////////

    task automatic checkEq(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual,
                     expected);
            $display("Result: FAILED");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    // Aligned beat address plus the lowest strobe lane of the first beat
    function automatic logic [ADDR_W-1:0] startAddr(input logic [ADDR_W-1:0] addr,
                                                     input logic [STRB_W-1:0] strb);
        int lane;
        lane = -1;
        for (int i = 0; i < STRB_W; i++)
        begin
            if (lane < 0 && strb[i])
                lane = i;
        end
        if (lane < 0)
            lane = 0;
        return (addr & ~32'h7) + ADDR_W'(lane);
    endfunction

    // Buffer writes and pending toggles counted over the whole run
    always @(posedge ACLK)
    begin
        prevPend <= wrTranPend;
        if (wrBufWrEn)
            writeCnt <= writeCnt + 1;
        if (wrTranPend !== prevPend)
            pendChanges <= pendChanges + 1;
    end

    // Hung run guard
    always @(posedge ACLK)
    begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt == CYCLE_LIMIT)
        begin
            $display("Timeout after %0d cycles, the bridge stopped responding", cycleCnt);
            $display("Result: FAILED");
            $fatal(1, "Simulation timeout");
        end
    end

    // AHB side model answers each pending toggle after 1 to 8 cycles
    initial
    begin
        int   waitCycles;
        logic seenPend;
        seenPend = 1'b0;
        // Pending level is only meaningful once reset is released
        wait (ARESETN === 1'b1);
        forever
        begin
            @(posedge ACLK);
            if (wrTranPend !== seenPend)
            begin
                seenPend = wrTranPend;
                waitCycles = 1 + ({$random(seed)} % 8);
                // Error level settles before the done toggle
                @(negedge ACLK);
                ahbError = curAhbErr;
                repeat (waitCycles) @(negedge ACLK);
                ahbWrDone = ~ahbWrDone;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // AXI master driver
    //////////////////////////////////////////////////////////////////////

    task automatic sendAddr(input rowT row, input logic [ID_W-1:0] id);
        @(negedge ACLK);
        AWVALID = 1'b1;
        AWADDR = row.addr;
        AWLEN = row.len;
        AWSIZE = row.size;
        AWBURST = row.burst;
        AWID = id;
        curAhbErr = row.ahbErr;
        // Idle bridge takes the address at once
        @(posedge ACLK);
        checkEq("AWREADY", 64'(AWREADY), 64'd1);
        @(negedge ACLK);
        AWVALID = 1'b0;
    endtask

    task automatic driveBeat(input int k, input logic [STRB_W-1:0] strb, input logic last,
                             input logic store);
        @(negedge ACLK);
        WVALID = 1'b1;
        WDATA[DATA_W-1:32] = $random(seed);
        WDATA[31:0] = $random(seed);
        WSTRB = strb;
        WLAST = last;
        @(posedge ACLK);
        while (!WREADY)
            @(posedge ACLK);
        // Buffer port is live in the handshake cycle
        checkEq("wrBufWrEn", 64'(wrBufWrEn), 64'(store));
        if (store)
        begin
            checkEq("wrBufAddr", 64'(wrBufAddr), 64'(k));
            checkEq("wrBufData", wrBufData, WDATA);
        end
    endtask

    task automatic collectResp(input logic immediate, input respT expResp,
                               input logic [ID_W-1:0] expId);
        int holdCycles;
        @(posedge ACLK);
        if (immediate)
            checkEq("BVALID", 64'(BVALID), 64'd1);
        else
        begin
            while (!BVALID)
                @(posedge ACLK);
        end
        checkEq("BRESP", 64'(BRESP), 64'(expResp));
        checkEq("BID", 64'(BID), 64'(expId));
        @(negedge ACLK);
        holdCycles = {$random(seed)} % 4;
        // Response must hold while BREADY is low
        repeat (holdCycles)
        begin
            @(posedge ACLK);
            checkEq("BVALID", 64'(BVALID), 64'd1);
            checkEq("BRESP", 64'(BRESP), 64'(expResp));
            checkEq("BID", 64'(BID), 64'(expId));
            @(negedge ACLK);
        end
        BREADY = 1'b1;
        @(posedge ACLK);
        checkEq("BVALID", 64'(BVALID), 64'd1);
        @(negedge ACLK);
        BREADY = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Table walk
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        rowT  row;
        int   nBeats;
        int   nStore;
        int   writesBefore;
        int   pendBefore;
        logic bad;
        logic legal;
        respT expResp;
        AWVALID = 1'b0;
        AWADDR = '0;
        AWLEN = '0;
        AWSIZE = '0;
        AWBURST = '0;
        AWID = '0;
        WVALID = 1'b0;
        WDATA = '0;
        WSTRB = '0;
        WLAST = 1'b0;
        BREADY = 1'b0;
        ahbWrDone = 1'b0;
        ahbError = 1'b0;
        curAhbErr = 1'b0;

        wait (ARESETN === 1'b1);
        @(posedge ACLK);
        checkEq("AWREADY", 64'(AWREADY), 64'd1);
        checkEq("WREADY", 64'(WREADY), 64'd0);
        checkEq("BVALID", 64'(BVALID), 64'd0);
        checkEq("wrBufWrEn", 64'(wrBufWrEn), 64'd0);
        checkEq("wrTranPend", 64'(wrTranPend), 64'd0);
        checkEq("validByteCnt", 64'(validByteCnt), 64'd0);

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            row = rows[r];
            bad = (row.burst == BURST_RSVD) || (row.burst == BURST_WRAP) ||
                  (row.size != SIZE_64);
            legal = !bad && (row.earlyLast == NO_EARLY) && !row.noLast;
            expResp = (!legal || row.ahbErr) ? RESP_SLVERR : RESP_OKAY;
            // Beats ahead of the first protocol error still reach the buffer
            if (bad)
                nStore = 0;
            else if (row.earlyLast != NO_EARLY)
                nStore = int'(row.earlyLast);
            else if (row.noLast)
                nStore = int'(row.len);
            else
                nStore = int'(row.len) + 1;
            // One extra beat carries the late WLAST
            nBeats = row.noLast ? int'(row.len) + 2 : int'(row.len) + 1;
            writesBefore = writeCnt;
            pendBefore = pendChanges;

            sendAddr(row, ID_W'(r));
            for (int k = 0; k < nBeats; k++)
            begin
                driveBeat(k, (k == 0) ? row.firstStrb : 8'hff,
                          row.noLast ? (k == nBeats - 1) :
                          ((k == int'(row.len)) || (k == int'(row.earlyLast))),
                          k < nStore);
            end
            @(negedge ACLK);
            WVALID = 1'b0;
            WLAST = 1'b0;
            // Error bursts answer right after the closing beat
            collectResp(!legal, expResp, ID_W'(r));

            if (legal)
            begin
                checkEq("ahbAddr", 64'(ahbAddr), 64'(startAddr(row.addr, row.firstStrb)));
                checkEq("validByteCnt", 64'(validByteCnt),
                        64'($countones(row.firstStrb) + 8 * int'(row.len)));
                checkEq("ahbLen", 64'(ahbLen), 64'(row.len));
                checkEq("ahbBurst", 64'(ahbBurst), 64'(row.burst));
            end
            checkEq("wrBufWrEn pulses", 64'(writeCnt - writesBefore), 64'(nStore));
            checkEq("wrTranPend toggles", 64'(pendChanges - pendBefore), legal ? 64'd1 : 64'd0);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: src.f
rtl/axiAhbPkg.sv
rtl/wrBeatIf.sv
rtl/axiWrCtrl.sv
rtl/wrBurstTracker.sv
rtl/strobeAccumulator.sv
rtl/axiToAhbWrBridge.sv
testbench/tbClockGen.sv
testbench/tbTop.sv

// File: Makefile
# Verilator build and run for the AXI to AHB write bridge
VERILATOR ?= verilator
TOP       ?= tbTop
FILELIST  ?= src.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
